/* rtl/save_mem_macros.svh */
`ifndef SAVE_MEM_MACROS_SVH
`define SAVE_MEM_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address window
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define SAVE_WINDOW_BASE 3'h5

// region upper bounds, each region starts at the previous end.
`define BUFFER_END 24'h00_2000
`define EEPROM_END 24'h00_2800
`define DD_END     24'h00_2C00
`define FLASH_END  24'h00_2C80

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bank depths in 16-bit words
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define BUFFER_DEPTH 4096
`define EEPROM_DEPTH 1024
`define DD_DEPTH     512
`define FLASH_DEPTH  64

`endif

/* rtl/save_mem_pkg.sv */
package save_mem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus address views
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // decode view, used to pick the region.
    typedef struct packed {
        logic [2:0]  base;     // window select.
        logic [23:0] offset;   // byte offset inside window.
    } save_region_t;

    // bank view, used to index the memories.
    typedef struct packed {
        logic [13:0] unused;
        logic [11:0] index;    // 16-bit word index.
        logic        lane;     // byte lane within word.
    } save_word_t;

    // Both views cover the same 27 bits. The banks only look at the low
    // word index bits they need; the region bits above are decoded by the
    // front stage.
    typedef union packed {
        save_region_t region;
        save_word_t   word;
    } save_addr_t;

endpackage

/* rtl/bus_frontend.sv */
`include "save_mem_macros.svh"

module bus_frontend (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    request,
    input  logic                    write,
    input  logic [1:0]              wmask,
    input  save_mem_pkg::save_addr_t address,
    input  logic [15:0]             wdata,

    input  logic [15:0]             buffer_rdata,
    input  logic [15:0]             eeprom_rdata_bus,
    input  logic [15:0]             dd_rdata_bus,
    input  logic [15:0]             flash_rdata_bus,

    output logic                    ack,
    output logic [15:0]             rdata,

    output logic                    write_strobe,
    output logic                    buffer_sel,
    output logic                    eeprom_sel,
    output logic                    dd_sel,
    output logic                    flash_sel
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request tracking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [1:0] last_request;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_request <= 2'b00;
            ack <= 1'b0;
        end else begin
            last_request <= {last_request[0], request};
            ack <= request && last_request[0] && !last_request[1];  // second edge seen.
        end
    end

    // first edge only.
    assign write_strobe = request && !last_request[0] && write;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // region decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic        in_window;
    logic [23:0] offset;

    assign in_window = (address.region.base == `SAVE_WINDOW_BASE);
    assign offset = address.region.offset;

    assign buffer_sel = in_window && (offset < `BUFFER_END);
    assign eeprom_sel = in_window && (offset >= `BUFFER_END) && (offset < `EEPROM_END);
    assign dd_sel     = in_window && (offset >= `EEPROM_END) && (offset < `DD_END);
    assign flash_sel  = in_window && (offset >= `DD_END) && (offset < `FLASH_END);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read return
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (buffer_sel) begin
            rdata <= buffer_rdata;
        end else if (eeprom_sel) begin
            rdata <= eeprom_rdata_bus;
        end else if (dd_sel) begin
            rdata <= dd_rdata_bus;
        end else if (flash_sel) begin
            rdata <= flash_rdata_bus;
        end else begin
            rdata <= 16'd0;  // unmapped reads as zero.
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        ack |=> !ack);

    select_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({buffer_sel, eeprom_sel, dd_sel, flash_sel}));

    // the requester holds its fields until it has seen ack.
    request_fields_held: assert property (@(posedge clk) disable iff (reset)
        request && last_request[0] |->
            $stable(address) && $stable(write) && $stable(wmask) && $stable(wdata));

endmodule

/* rtl/buffer_bank.sv */
`include "save_mem_macros.svh"

module buffer_bank (
    input  logic                    clk,

    input  logic                    write_strobe,
    input  logic                    buffer_sel,
    input  save_mem_pkg::save_addr_t address,
    input  logic [1:0]              wmask,
    input  logic [15:0]             wdata,

    output logic [15:0]             buffer_rdata
);

    localparam int ADDR_W = $clog2(`BUFFER_DEPTH);

    logic [15:0]       mem [0:`BUFFER_DEPTH-1];
    logic [ADDR_W-1:0] index;

    assign index = address.word.index[ADDR_W-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte-masked write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (write_strobe && buffer_sel) begin
            if (wmask[1]) begin
                mem[index][15:8] <= wdata[15:8];
            end
            if (wmask[0]) begin
                mem[index][7:0] <= wdata[7:0];
            end
        end
    end

    // read every cycle, front stage picks it up.
    always_ff @(posedge clk) begin
        buffer_rdata <= mem[index];
    end

endmodule

/* rtl/eeprom_bank.sv */
`include "save_mem_macros.svh"

module eeprom_bank (
    input  logic                    clk,

    input  logic                    write_strobe,
    input  logic                    eeprom_sel,
    input  save_mem_pkg::save_addr_t address,
    input  logic [1:0]              wmask,
    input  logic [15:0]             wdata,

    input  logic                    eeprom_write,
    input  logic [10:0]             eeprom_address,
    input  logic [7:0]              eeprom_wdata,

    output logic [15:0]             eeprom_rdata_bus,
    output logic [7:0]              eeprom_rdata
);

    localparam int ADDR_W = $clog2(`EEPROM_DEPTH);

    // high byte sits at even console addresses.
    logic [7:0] mem_high [0:`EEPROM_DEPTH-1];
    logic [7:0] mem_low  [0:`EEPROM_DEPTH-1];

    logic [ADDR_W-1:0] bus_index;
    logic [ADDR_W-1:0] con_index;
    logic              bus_write_high;
    logic              bus_write_low;
    logic              con_write_high;
    logic              con_write_low;
    logic [7:0]        con_high_rdata;
    logic [7:0]        con_low_rdata;

    assign bus_index = address.word.index[ADDR_W-1:0];
    assign con_index = eeprom_address[ADDR_W:1];

    assign bus_write_high = write_strobe && eeprom_sel && wmask[1];
    assign bus_write_low  = write_strobe && eeprom_sel && wmask[0];
    assign con_write_high = eeprom_write && !eeprom_address[0];
    assign con_write_low  = eeprom_write && eeprom_address[0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // byte halves
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (bus_write_high) mem_high[bus_index] <= wdata[15:8];
        if (con_write_high) mem_high[con_index] <= eeprom_wdata;
        eeprom_rdata_bus[15:8] <= mem_high[bus_index];
        con_high_rdata <= mem_high[con_index];
    end

    always_ff @(posedge clk) begin
        if (bus_write_low) mem_low[bus_index] <= wdata[7:0];
        if (con_write_low) mem_low[con_index] <= eeprom_wdata;
        eeprom_rdata_bus[7:0] <= mem_low[bus_index];
        con_low_rdata <= mem_low[con_index];
    end

    // console address is held, so bit 0 still picks the half.
    assign eeprom_rdata = eeprom_address[0] ? con_low_rdata : con_high_rdata;

    no_byte_collision: assert property (@(posedge clk)
        !((bus_write_high && con_write_high) || (bus_write_low && con_write_low))
            || (bus_index != con_index));

endmodule

/* rtl/dd_flash_banks.sv */
`include "save_mem_macros.svh"

module dd_flash_banks (
    input  logic                    clk,

    input  logic                    write_strobe,
    input  logic                    dd_sel,
    input  logic                    flash_sel,
    input  save_mem_pkg::save_addr_t address,
    input  logic [15:0]             wdata,

    input  logic                    dd_write,
    input  logic [6:0]              dd_address,
    input  logic [15:0]             dd_wdata,

    input  logic                    flash_write,
    input  logic [5:0]              flash_address,
    input  logic [15:0]             flash_wdata,

    output logic [15:0]             dd_rdata_bus,
    output logic [15:0]             flash_rdata_bus,
    output logic [15:0]             dd_rdata
);

    localparam int DD_AW    = $clog2(`DD_DEPTH);
    localparam int FLASH_AW = $clog2(`FLASH_DEPTH);

    logic [15:0] dd_mem    [0:`DD_DEPTH-1];
    logic [15:0] flash_mem [0:`FLASH_DEPTH-1];

    logic [DD_AW-1:0] dd_bus_index;
    logic [DD_AW-1:0] dd_con_index;
    logic             bus_write;

    assign dd_bus_index = address.word.index[DD_AW-1:0];
    assign dd_con_index = {{(DD_AW-7){1'b0}}, dd_address};  // console sees first 128 words.

    // flash region is console-only, drop bus writes there.
    assign bus_write = write_strobe && !flash_sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // disk-drive buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (bus_write && dd_sel) dd_mem[dd_bus_index] <= wdata;
        if (dd_write) dd_mem[dd_con_index] <= dd_wdata;
        dd_rdata_bus <= dd_mem[dd_bus_index];
        dd_rdata <= dd_mem[dd_con_index];
    end

    no_word_collision: assert property (@(posedge clk)
        !(bus_write && dd_sel && dd_write) || (dd_bus_index != dd_con_index));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // flashram page buffer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (flash_write) flash_mem[flash_address] <= flash_wdata;
        flash_rdata_bus <= flash_mem[address.word.index[FLASH_AW-1:0]];
    end

endmodule

/* rtl/save_memory_top.sv */
module save_memory_top (
    input  logic                    clk,
    input  logic                    reset,

    input  logic                    request,
    input  logic                    write,
    input  save_mem_pkg::save_addr_t address,
    input  logic [1:0]              wmask,
    input  logic [15:0]             wdata,
    output logic                    ack,
    output logic [15:0]             rdata,

    input  logic                    eeprom_write,
    input  logic [10:0]             eeprom_address,
    input  logic [7:0]              eeprom_wdata,
    output logic [7:0]              eeprom_rdata,

    input  logic                    dd_write,
    input  logic [6:0]              dd_address,
    input  logic [15:0]             dd_wdata,
    output logic [15:0]             dd_rdata,

    input  logic                    flash_write,
    input  logic [5:0]              flash_address,
    input  logic [15:0]             flash_wdata
);

    logic        write_strobe;
    logic        buffer_sel;
    logic        eeprom_sel;
    logic        dd_sel;
    logic        flash_sel;
    logic [15:0] buffer_rdata;
    logic [15:0] eeprom_rdata_bus;
    logic [15:0] dd_rdata_bus;
    logic [15:0] flash_rdata_bus;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bus front stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    bus_frontend u_frontend (
        .clk, .reset,
        .request, .write, .wmask, .address, .wdata,
        .buffer_rdata, .eeprom_rdata_bus, .dd_rdata_bus, .flash_rdata_bus,
        .ack, .rdata,
        .write_strobe, .buffer_sel, .eeprom_sel, .dd_sel, .flash_sel
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // banks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    buffer_bank u_buffer (
        .clk, .write_strobe, .buffer_sel, .address, .wmask, .wdata,
        .buffer_rdata
    );

    eeprom_bank u_eeprom (
        .clk, .write_strobe, .eeprom_sel, .address, .wmask, .wdata,
        .eeprom_write, .eeprom_address, .eeprom_wdata,
        .eeprom_rdata_bus, .eeprom_rdata
    );

    dd_flash_banks u_dd_flash (
        .clk, .write_strobe, .dd_sel, .flash_sel, .address, .wdata,
        .dd_write, .dd_address, .dd_wdata,
        .flash_write, .flash_address, .flash_wdata,
        .dd_rdata_bus, .flash_rdata_bus, .dd_rdata
    );

endmodule

/* dv/tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // period of 4.
    end

    initial begin
        reset = 1'b1;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

/* dv/save_memory_tb.sv */
`include "save_mem_macros.svh"

module save_memory_tb;

    import save_mem_pkg::*;

    localparam int BUFFER_WORDS   = 16;
    localparam int EEPROM_WORDS   = 8;
    localparam int DD_WORDS       = 8;
    localparam int FLASH_WORDS    = 8;
    localparam int UNMAPPED_CASES = 8;
    localparam int ACK_CASES      = 8;
    localparam int BUS_TXNS = 3 * BUFFER_WORDS + 2 * EEPROM_WORDS + 2 * DD_WORDS
        + 3 * FLASH_WORDS + 4 * UNMAPPED_CASES + ACK_CASES;
    localparam int CONSOLE_OPS = 3 * EEPROM_WORDS + 2 * DD_WORDS + FLASH_WORDS;
    localparam int CYCLE_LIMIT = 8 * (BUS_TXNS + CONSOLE_OPS) + 200;

    logic        clk;
    logic        reset;
    logic        request;
    logic        write;
    save_addr_t  address;
    logic [1:0]  wmask;
    logic [15:0] wdata;
    logic        ack;
    logic [15:0] rdata;
    logic        eeprom_write;
    logic [10:0] eeprom_address;
    logic [7:0]  eeprom_wdata;
    logic [7:0]  eeprom_rdata;
    logic        dd_write;
    logic [6:0]  dd_address;
    logic [15:0] dd_wdata;
    logic [15:0] dd_rdata;
    logic        flash_write;
    logic [5:0]  flash_address;
    logic [15:0] flash_wdata;

    // reference model holds one word array per region.
    logic [15:0] buffer_model [0:`BUFFER_DEPTH-1];
    logic [15:0] eeprom_model [0:`EEPROM_DEPTH-1];
    logic [15:0] dd_model     [0:`DD_DEPTH-1];
    logic [15:0] flash_model  [0:`FLASH_DEPTH-1];
    logic [11:0] buffer_words [0:BUFFER_WORDS-1];

    logic        checks_on = 1'b0;
    logic [1:0]  req_seen;
    logic        read_pending;
    logic [15:0] expected_rdata;
    logic        eeprom_check;
    logic [7:0]  eeprom_expected;
    logic        dd_check;
    logic [15:0] dd_expected;
    logic [31:0] lcg_state = 32'hb684;
    int          cycle_count = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_count = 0;
    int          test_checks = 0;
    int          test_errors = 0;
    string       test_name = "reset";

    tb_clock_gen clock_gen (.clk, .reset);

    save_memory_top DUT (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks sampled mid-cycle
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // ack belongs to the cycle after the second edge with request high.
    always @(posedge clk) begin
        if (reset) begin
            checks_on <= 1'b1;
            req_seen <= 2'd0;
        end else if (request) begin
            req_seen <= (req_seen == 2'd3) ? 2'd3 : req_seen + 2'd1;
        end else begin
            req_seen <= 2'd0;
        end
    end

    ack_after_second_edge: assert property (@(negedge clk) disable iff (!checks_on)
        ack == (req_seen == 2'd2))
        else begin
            $display("error %s: ack expected %0b, actual %0b", test_name, req_seen == 2'd2, ack);
            error_count++;
        end

    bus_read_data: assert property (@(negedge clk) disable iff (!checks_on)
        ack && read_pending |-> rdata == expected_rdata)
        else begin
            $display("error %s: rdata expected %h, actual %h", test_name, expected_rdata, rdata);
            error_count++;
        end

    eeprom_read_data: assert property (@(negedge clk) disable iff (!checks_on)
        eeprom_check |-> eeprom_rdata == eeprom_expected)
        else begin
            $display("error %s: eeprom_rdata expected %h, actual %h", test_name,
                     eeprom_expected, eeprom_rdata);
            error_count++;
        end

    dd_read_data: assert property (@(negedge clk) disable iff (!checks_on)
        dd_check |-> dd_rdata == dd_expected)
        else begin
            $display("error %s: dd_rdata expected %h, actual %h", test_name,
                     dd_expected, dd_rdata);
            error_count++;
        end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("Regression failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] expected_word(input logic [26:0] addr);
        logic [23:0] off;
        logic [23:0] idx;
        off = addr[23:0];
        if (addr[26:24] != `SAVE_WINDOW_BASE || off >= `FLASH_END) return 16'h0000;
        if (off < `BUFFER_END) begin
            idx = off >> 1;
            return buffer_model[idx[11:0]];
        end
        if (off < `EEPROM_END) begin
            idx = (off - `BUFFER_END) >> 1;
            return eeprom_model[idx[9:0]];
        end
        if (off < `DD_END) begin
            idx = (off - `EEPROM_END) >> 1;
            return dd_model[idx[8:0]];
        end
        idx = (off - `DD_END) >> 1;
        return flash_model[idx[5:0]];
    endfunction

    // flash and unmapped offsets keep their contents.
    function automatic void apply_to_model(input logic [26:0] addr, input logic [1:0] mask,
                                           input logic [15:0] data);
        logic [23:0] off;
        logic [23:0] idx;
        off = addr[23:0];
        if (addr[26:24] != `SAVE_WINDOW_BASE) return;
        if (off < `BUFFER_END) begin
            idx = off >> 1;
            if (mask[1]) buffer_model[idx[11:0]][15:8] = data[15:8];
            if (mask[0]) buffer_model[idx[11:0]][7:0] = data[7:0];
        end else if (off < `EEPROM_END) begin
            idx = (off - `BUFFER_END) >> 1;
            if (mask[1]) eeprom_model[idx[9:0]][15:8] = data[15:8];
            if (mask[0]) eeprom_model[idx[9:0]][7:0] = data[7:0];
        end else if (off < `DD_END) begin
            idx = (off - `EEPROM_END) >> 1;
            dd_model[idx[8:0]] = data;
        end
    endfunction

    task automatic bus_access(input logic [26:0] addr, input logic wr, input logic [1:0] mask,
                              input logic [15:0] data);
        @(posedge clk);
        request <= 1'b1;
        write <= wr;
        address <= addr;
        wmask <= mask;
        wdata <= data;
        read_pending <= !wr;
        expected_rdata <= expected_word(addr);  // writes return the old word.
        if (wr) apply_to_model(addr, mask, data);
        else check_count++;
        @(posedge clk);
        while (!ack) @(posedge clk);
        request <= 1'b0;
        read_pending <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic eeprom_store(input logic [10:0] byte_addr, input logic [7:0] data);
        @(posedge clk);
        eeprom_write <= 1'b1;
        eeprom_address <= byte_addr;
        eeprom_wdata <= data;
        if (byte_addr[0]) eeprom_model[byte_addr[10:1]][7:0] = data;
        else eeprom_model[byte_addr[10:1]][15:8] = data;
        @(posedge clk);
        eeprom_write <= 1'b0;
    endtask

    task automatic eeprom_fetch(input logic [10:0] byte_addr);
        @(posedge clk);
        eeprom_address <= byte_addr;
        @(posedge clk);
        eeprom_check <= 1'b1;
        eeprom_expected <= byte_addr[0] ? eeprom_model[byte_addr[10:1]][7:0]
                                        : eeprom_model[byte_addr[10:1]][15:8];
        check_count++;
        @(posedge clk);
        eeprom_check <= 1'b0;
    endtask

    task automatic dd_store(input logic [6:0] word, input logic [15:0] data);
        @(posedge clk);
        dd_write <= 1'b1;
        dd_address <= word;
        dd_wdata <= data;
        dd_model[{2'b00, word}] = data;
        @(posedge clk);
        dd_write <= 1'b0;
    endtask

    task automatic dd_fetch(input logic [6:0] word);
        @(posedge clk);
        dd_address <= word;
        @(posedge clk);
        dd_check <= 1'b1;
        dd_expected <= dd_model[{2'b00, word}];
        check_count++;
        @(posedge clk);
        dd_check <= 1'b0;
    endtask

    task automatic flash_store(input logic [5:0] word, input logic [15:0] data);
        @(posedge clk);
        flash_write <= 1'b1;
        flash_address <= word;
        flash_wdata <= data;
        flash_model[word] = data;
        @(posedge clk);
        flash_write <= 1'b0;
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic report_test();
        test_count++;
        $display("test %s finished: %0d checks, %0d errors", test_name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [23:0] off;
        logic [2:0]  base;
        logic [11:0] alias_word;

        request <= 1'b0;
        write <= 1'b0;
        address <= '0;
        wmask <= 2'b00;
        wdata <= 16'h0000;
        eeprom_write <= 1'b0;
        eeprom_address <= 11'd0;
        eeprom_wdata <= 8'h00;
        dd_write <= 1'b0;
        dd_address <= 7'd0;
        dd_wdata <= 16'h0000;
        flash_write <= 1'b0;
        flash_address <= 6'd0;
        flash_wdata <= 16'h0000;
        read_pending <= 1'b0;
        eeprom_check <= 1'b0;
        dd_check <= 1'b0;
        @(negedge reset);

        begin_test("buffer_masks");
        for (int i = 0; i < BUFFER_WORDS; i++) begin
            r = next_random();
            s = next_random();
            buffer_words[i] = r[27:16];
            off = {11'd0, r[27:16], 1'b0};
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b1, 2'b11, s[31:16]);
            r = next_random();
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b1, r[9:8], r[31:16]);
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b0, 2'b00, 16'h0000);
        end
        report_test();

        begin_test("eeprom_cross");
        for (int i = 0; i < EEPROM_WORDS; i++) begin
            r = next_random();
            s = next_random();
            off = `BUFFER_END + {13'd0, r[25:16], 1'b0};
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b1, 2'b11, s[31:16]);
            eeprom_fetch({r[25:16], 1'b0});
            eeprom_fetch({r[25:16], 1'b1});
            // console byte always differs from the one the bus wrote.
            eeprom_store({r[25:16], s[12]}, s[12] ? ~s[23:16] : ~s[31:24]);
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b0, 2'b00, 16'h0000);
        end
        report_test();

        begin_test("dd_cross");
        for (int i = 0; i < DD_WORDS; i++) begin
            r = next_random();
            s = next_random();
            off = `EEPROM_END + {16'd0, r[22:16], 1'b0};
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b1, 2'b11, s[31:16]);
            dd_fetch(r[22:16]);
            s = next_random();
            dd_store(r[22:16], s[31:16]);
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b0, 2'b00, 16'h0000);
        end
        report_test();

        begin_test("flash_readonly");
        for (int i = 0; i < FLASH_WORDS; i++) begin
            r = next_random();
            s = next_random();
            off = `DD_END + {17'd0, r[21:16], 1'b0};
            flash_store(r[21:16], s[31:16]);
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b0, 2'b00, 16'h0000);
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b1, 2'b11, ~s[31:16]);
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b0, 2'b00, 16'h0000);
        end
        report_test();

        // each unmapped address aliases a buffer word in the bank index bits.
        begin_test("unmapped");
        for (int i = 0; i < UNMAPPED_CASES; i++) begin
            r = next_random();
            s = next_random();
            off = r[31:8];
            base = s[18:16];
            if (i % 2 == 0) begin
                if (base == `SAVE_WINDOW_BASE) base = 3'h2;
            end else begin
                base = `SAVE_WINDOW_BASE;
                if (off < `FLASH_END) off = off | 24'h80_0000;
            end
            alias_word = off[12:1];
            bus_access({`SAVE_WINDOW_BASE, 11'd0, alias_word, 1'b0}, 1'b1, 2'b11, s[31:16]);
            bus_access({base, off}, 1'b1, 2'b11, ~s[31:16]);
            bus_access({base, off}, 1'b0, 2'b00, 16'h0000);
            bus_access({`SAVE_WINDOW_BASE, 11'd0, alias_word, 1'b0}, 1'b0, 2'b00, 16'h0000);
        end
        report_test();

        begin_test("ack_timing");
        for (int i = 0; i < ACK_CASES; i++) begin
            r = next_random();
            off = {11'd0, buffer_words[r[19:16]], 1'b0};
            bus_access({`SAVE_WINDOW_BASE, off}, 1'b0, 2'b00, 16'h0000);
            repeat (r[25:24]) @(posedge clk);  // vary the idle gap.
        end
        report_test();

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+rtl
rtl/save_mem_pkg.sv
rtl/bus_frontend.sv
rtl/buffer_bank.sv
rtl/eeprom_bank.sv
rtl/dd_flash_banks.sv
rtl/save_memory_top.sv
dv/tb_clock_gen.sv
dv/save_memory_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= save_memory_tb
FILE_LIST  ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
FAIL_TEXT  ?= Regression failed
PASS_TEXT  ?= Regression passed
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_TEXT)" $(LOG) || \
	   ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
